// File: logic/tea_pkg.sv
// TEA accelerator shared definitions
// Widths, cipher constants, register map and bus/job structs

package tea_pkg;

	typedef logic [31:0] word_t;
	typedef logic [7:0]  tag_t;
	typedef logic [7:0]  apb_addr_t;

	//////////////////////////////////////////////////
	// Cipher constants
	localparam word_t tea_key [4] = '{
		32'h01234567,
		32'h89abcdef,
		32'h13579248,
		32'h248a0135
	};
	localparam word_t tea_delta = 32'h9e3779b9;

	//////////////////////////////////////////////////
	// Register map where the launch offset reads back status
	localparam apb_addr_t reg_data0     = 8'h00;
	localparam apb_addr_t reg_data1     = 8'h04;
	localparam apb_addr_t reg_launch    = 8'h08;
	localparam apb_addr_t reg_result_lo = 8'h0c;
	localparam apb_addr_t reg_result_hi = 8'h10;

	typedef struct packed {
		tag_t  tag;
		word_t v0;
		word_t v1;
	} tea_job_t;

	typedef struct packed {
		tag_t  tag;
		word_t v0;
		word_t v1;
	} tea_result_t;

	typedef struct packed {
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_addr_t paddr;
		word_t     pwdata;
	} apb_req_t;

	typedef struct packed {
		logic  pready;
		word_t prdata;
		logic  pslverr;
	} apb_rsp_t;

	typedef enum logic [1:0] {
		idle,
		setup,
		access
	} apb_state_t;

endpackage

// File: logic/tea_result_queue.sv
// TEA result queue
// Circular buffer collecting lane results by lowest-index priority
`timescale 1ns/1ps

module tea_result_queue #(
	parameter int LANES       = 3,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic [LANES-1:0]     lane_valid,
	input  tea_pkg::tea_result_t lane_result [LANES],
	input  logic                 pop,
	output logic [LANES-1:0]     lane_accept,
	output tea_pkg::tea_result_t head,
	output logic [7:0]           count,
	output logic                 empty
);
	import tea_pkg::*;

	localparam int PW = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

	tea_result_t mem [QUEUE_DEPTH];
	tea_result_t push_data;
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic          full;
	logic          push;

	assign full  = (count == 8'(QUEUE_DEPTH));
	assign empty = (count == 8'd0);

	always_comb
	begin
		lane_accept = '0;
		push_data = lane_result[0];
		for (int i = LANES - 1; i >= 0; i--)
		begin
			if (lane_valid[i] && !full)
			begin
				lane_accept = '0;
				lane_accept[i] = 1'b1;
				push_data = lane_result[i];
			end
		end
	end

	assign push = |lane_accept;

	//////////////////////////////////////////////////
	// Pointers and count
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= 8'd0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PW'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count <= count + {7'd0, push} - {7'd0, pop};
		end
	end

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wr_ptr] <= push_data;
	end

	assign head = mem[rd_ptr];

	a_no_overflow: assert property (@(posedge clk) disable iff (reset)
		count <= 8'(QUEUE_DEPTH));
	a_no_underflow: assert property (@(posedge clk) disable iff (reset)
		pop |-> !empty);

endmodule

// File: logic/tea_lane.sv
// TEA lane
// Iterative encryption engine, one round per clock, holds its result until taken
`timescale 1ns/1ps

module tea_lane #(
	parameter int ROUNDS = 32
) (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 start,
	input  tea_pkg::tea_job_t    job,
	input  logic                 accept,
	output logic                 busy,
	output logic                 valid,
	output tea_pkg::tea_result_t result
);
	import tea_pkg::*;

	localparam int CW = $clog2(ROUNDS + 1);

	logic          running;
	logic [CW-1:0] round_cnt;
	tag_t          tag_q;
	word_t         v0_q;
	word_t         v1_q;
	word_t         sum_q;
	word_t         v0_next;
	word_t         v1_next;

	// One TEA round
	assign v0_next = v0_q + (((v1_q << 4) + tea_key[0]) ^ (v1_q + sum_q) ^
		((v1_q >> 5) + tea_key[1]));
	assign v1_next = v1_q + (((v0_next << 4) + tea_key[2]) ^ (v0_next + sum_q) ^
		((v0_next >> 5) + tea_key[3]));

	//////////////////////////////////////////////////
	// Round control
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			running <= 1'b0;
			valid <= 1'b0;
			round_cnt <= '0;
		end
		else if (start)
		begin
			running <= 1'b1;
			round_cnt <= '0;
		end
		else if (running)
		begin
			round_cnt <= round_cnt + 1'b1;
			if (round_cnt == CW'(ROUNDS - 1))
			begin
				running <= 1'b0;
				valid <= 1'b1;
			end
		end
		else if (valid && accept)
			valid <= 1'b0;
	end

	// Datapath with the sum starting at delta for round one
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			tag_q <= job.tag;
			v0_q <= job.v0;
			v1_q <= job.v1;
			sum_q <= tea_delta;
		end
		else if (running)
		begin
			v0_q <= v0_next;
			v1_q <= v1_next;
			sum_q <= sum_q + tea_delta;
		end
	end

	assign busy   = running || valid;
	assign result = '{tag: tag_q, v0: v0_q, v1: v1_q};

	a_start_idle: assert property (@(posedge clk) disable iff (reset)
		start |-> !busy);

endmodule

// File: logic/tea_apb_regs.sv
// TEA APB register block
// Holds the data words, dispatches launches to free lanes, serves status and results
`timescale 1ns/1ps

module tea_apb_regs #(
	parameter int LANES = 3
) (
	input  logic                 clk,
	input  logic                 reset,
	input  tea_pkg::apb_req_t    apb,
	input  logic [LANES-1:0]     lane_busy,
	input  tea_pkg::tea_result_t head,
	input  logic [7:0]           queue_count,
	input  logic                 queue_empty,
	output tea_pkg::apb_rsp_t    rsp,
	output logic [LANES-1:0]     lane_start,
	output tea_pkg::tea_job_t    job,
	output logic                 pop
);
	import tea_pkg::*;

	apb_state_t       state;
	apb_state_t       state_next;
	word_t            data0;
	word_t            data1;
	word_t            status;
	word_t            rdata;
	logic             rd_err;
	logic             pready;
	logic             wr_xfer;
	logic             rd_xfer;
	logic             launch;
	logic             launch_fail;
	logic [LANES-1:0] free_pick;
	logic [7:0]       free_count;

	//////////////////////////////////////////////////
	// Bus FSM with one wait state per transfer
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			state <= idle;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = idle;
		case (state)
			idle:
				if (apb.psel && !apb.penable)
					state_next = setup;
			setup:
				if (apb.psel && apb.penable)
					state_next = access;
			default:
				state_next = idle;
		endcase
	end

	assign pready  = (state == access);
	assign wr_xfer = pready && apb.pwrite;
	assign rd_xfer = pready && !apb.pwrite;

	always_ff @(posedge clk)
	begin
		if (wr_xfer && apb.paddr == reg_data0)
			data0 <= apb.pwdata;
		if (wr_xfer && apb.paddr == reg_data1)
			data1 <= apb.pwdata;
	end

	//////////////////////////////////////////////////
	// Lowest free lane wins
	always_comb
	begin : pick_lane
		logic found;
		found = 1'b0;
		free_pick = '0;
		free_count = 8'd0;
		for (int i = 0; i < LANES; i++)
		begin
			if (!lane_busy[i])
			begin
				free_count = free_count + 8'd1;
				if (!found)
					free_pick[i] = 1'b1;
				found = 1'b1;
			end
		end
	end

	assign launch      = wr_xfer && apb.paddr == reg_launch;
	assign launch_fail = launch && !(|free_pick);
	assign lane_start  = launch ? free_pick : '0;
	assign job         = '{tag: apb.pwdata[7:0], v0: data0, v1: data1};
	assign pop         = rd_xfer && apb.paddr == reg_result_hi && !queue_empty;

	// Head tag, queue count, free lanes
	assign status = {8'h00, free_count, queue_count, head.tag};

	always_comb
	begin
		rdata = '0;
		rd_err = 1'b0;
		case (apb.paddr)
			reg_data0:     rdata = data0;
			reg_data1:     rdata = data1;
			reg_launch:    rdata = status;
			reg_result_lo:
			begin
				rdata = queue_empty ? '0 : head.v0;
				rd_err = queue_empty;
			end
			reg_result_hi:
			begin
				rdata = queue_empty ? '0 : head.v1;
				rd_err = queue_empty;
			end
			default:       rdata = '0;
		endcase
	end

	assign rsp = '{
		pready:  pready,
		prdata:  rd_xfer ? rdata : '0,
		pslverr: (rd_xfer && rd_err) || launch_fail
	};

	// Access phase is always entered through a setup cycle
	a_setup_first: assert property (@(posedge clk) disable iff (reset)
		$rose(apb.penable) |-> $past(apb.psel && !apb.penable));

endmodule

// File: logic/tea_accel_top.sv
// TEA accelerator top
// APB register block, a row of TEA lanes and the result queue
`timescale 1ns/1ps

module tea_accel_top #(
	parameter int LANES       = 3,
	parameter int ROUNDS      = 32,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  tea_pkg::apb_req_t apb,
	output tea_pkg::apb_rsp_t rsp
);
	import tea_pkg::*;

	logic [LANES-1:0] lane_start;
	logic [LANES-1:0] lane_busy;
	logic [LANES-1:0] lane_valid;
	logic [LANES-1:0] lane_accept;
	tea_job_t         job;
	tea_result_t      lane_result [LANES];
	tea_result_t      head;
	logic [7:0]       queue_count;
	logic             queue_empty;
	logic             pop;

	tea_apb_regs #(
		.LANES (LANES)
	) tea_apb_regs_i (
		.clk         (clk),
		.reset       (reset),
		.apb         (apb),
		.lane_busy   (lane_busy),
		.head        (head),
		.queue_count (queue_count),
		.queue_empty (queue_empty),
		.rsp         (rsp),
		.lane_start  (lane_start),
		.job         (job),
		.pop         (pop)
	);

	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		tea_lane #(
			.ROUNDS (ROUNDS)
		) tea_lane_i (
			.clk    (clk),
			.reset  (reset),
			.start  (lane_start[i]),
			.job    (job),
			.accept (lane_accept[i]),
			.busy   (lane_busy[i]),
			.valid  (lane_valid[i]),
			.result (lane_result[i])
		);
	end

	tea_result_queue #(
		.LANES       (LANES),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) tea_result_queue_i (
		.clk         (clk),
		.reset       (reset),
		.lane_valid  (lane_valid),
		.lane_result (lane_result),
		.pop         (pop),
		.lane_accept (lane_accept),
		.head        (head),
		.count       (queue_count),
		.empty       (queue_empty)
	);

endmodule

// File: bench/tea_checker.sv
// TEA accelerator checker
// Watches the APB ports, predicts results with a reference model and counts errors
`timescale 1ns/1ps

module tea_checker #(
	parameter int LANES       = 3,
	parameter int ROUNDS      = 32,
	parameter int QUEUE_DEPTH = 4
) (
	input  logic              clk,
	input  logic              reset,
	input  tea_pkg::apb_req_t apb,
	input  tea_pkg::apb_rsp_t rsp,
	input  logic              expect_err,
	output int                errors,
	output int                checks
);
	import tea_pkg::*;

	// Expected results of accepted launches in issue order
	tea_result_t pending [$];
	word_t       data0_model;
	word_t       data1_model;
	int          access_n;

	function automatic tea_result_t encrypt_ref(tag_t tag, word_t v0, word_t v1);
		word_t y;
		word_t z;
		word_t sum;
		y = v0;
		z = v1;
		sum = 32'd0;
		for (int r = 1; r <= ROUNDS; r++)
		begin
			sum = sum + tea_delta;
			y = y + (((z << 4) + tea_key[0]) ^ (z + sum) ^ ((z >> 5) + tea_key[1]));
			z = z + (((y << 4) + tea_key[2]) ^ (y + sum) ^ ((y >> 5) + tea_key[3]));
		end
		return '{tag: tag, v0: y, v1: z};
	endfunction

	task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_status(input word_t status);
		int count;
		int free_exp;
		count = int'(status[15:8]);
		free_exp = LANES - (pending.size() - count);
		compare("status upper byte", 32'(status[31:24]), 32'd0);
		if (count > pending.size() || count > QUEUE_DEPTH)
		begin
			errors = errors + 1;
			$display("ERROR %0t: queue count %0d with %0d jobs outstanding", $time, count,
				pending.size());
		end
		else
		begin
			compare("status free lanes", 32'(status[23:16]), 32'(free_exp));
			if (count > 0)
				compare("status head tag", 32'(status[7:0]), 32'(pending[0].tag));
		end
	endtask

	task automatic no_job_error();
		errors = errors + 1;
		$display("ERROR %0t: result read succeeded with no job outstanding", $time);
	endtask

	//////////////////////////////////////////////////
	// Completed transfers are sampled in their pready cycle
	always @(posedge clk)
	begin : watch
		tea_result_t front;
		if (reset)
		begin
			errors = 0;
			checks = 0;
			access_n = 0;
			pending.delete();
		end
		else
		begin
			// Ready only in the second access cycle
			if (apb.psel && apb.penable)
				access_n = access_n + 1;
			else
				access_n = 0;
			compare("pready", 32'(rsp.pready), 32'(access_n == 2));
			if (rsp.pready)
			begin
				compare("pslverr", 32'(rsp.pslverr), 32'(expect_err));
				if (apb.pwrite)
				begin
					if (apb.paddr == reg_data0)
						data0_model = apb.pwdata;
					if (apb.paddr == reg_data1)
						data1_model = apb.pwdata;
					if (apb.paddr == reg_launch && !rsp.pslverr)
						pending.push_back(encrypt_ref(apb.pwdata[7:0], data0_model,
							data1_model));
				end
				else if (rsp.pslverr)
					compare("read data on error", rsp.prdata, 32'd0);
				else
				begin
					case (apb.paddr)
						reg_data0:  compare("data0 readback", rsp.prdata, data0_model);
						reg_data1:  compare("data1 readback", rsp.prdata, data1_model);
						reg_launch: check_status(rsp.prdata);
						reg_result_lo:
							if (pending.size() == 0)
								no_job_error();
							else
							begin
								front = pending[0];
								compare("result v0", rsp.prdata, front.v0);
							end
						reg_result_hi:
							if (pending.size() == 0)
								no_job_error();
							else
							begin
								front = pending.pop_front();
								compare("result v1", rsp.prdata, front.v1);
							end
						default:    compare("unmapped read", rsp.prdata, 32'd0);
					endcase
				end
			end
		end
	end

endmodule

// File: bench/tea_accel_tb.sv
// TEA accelerator testbench
// Clock, reset, APB driver and the stimulus sequence
`timescale 1ns/1ps

module tea_accel_tb;
	import tea_pkg::*;

	localparam int LANES       = 3;
	localparam int ROUNDS      = 32;
	localparam int QUEUE_DEPTH = 4;
	localparam int CYCLE_LIMIT = 200 * (ROUNDS + 10);

	logic     clk;
	logic     reset;
	apb_req_t apb;
	apb_rsp_t rsp;
	logic     expect_err;
	int       errors;
	int       checks;
	int       seed = 32'hfad3;
	int       cycles = 0;
	tag_t     next_tag;

	tea_accel_top #(
		.LANES       (LANES),
		.ROUNDS      (ROUNDS),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) tea_accel_top_i (
		.clk   (clk),
		.reset (reset),
		.apb   (apb),
		.rsp   (rsp)
	);

	tea_checker #(
		.LANES       (LANES),
		.ROUNDS      (ROUNDS),
		.QUEUE_DEPTH (QUEUE_DEPTH)
	) tea_checker_i (
		.clk        (clk),
		.reset      (reset),
		.apb        (apb),
		.rsp        (rsp),
		.expect_err (expect_err),
		.errors     (errors),
		.checks     (checks)
	);

	initial
		clk = 1'b0;
	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// APB driver that changes inputs on the falling edge
	task automatic bus_transfer(input logic write, input apb_addr_t addr, input word_t wdata,
		input logic err, output word_t rdata);
		@(negedge clk);
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = write;
		apb.paddr = addr;
		apb.pwdata = wdata;
		expect_err = err;
		@(negedge clk);
		apb.penable = 1'b1;
		do
			@(negedge clk);
		while (!rsp.pready);
		rdata = rsp.prdata;
		@(negedge clk);
		apb.psel = 1'b0;
		apb.penable = 1'b0;
		expect_err = 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input word_t data, input logic err);
		word_t unused;
		bus_transfer(1'b1, addr, data, err, unused);
	endtask

	task automatic apb_read(input apb_addr_t addr, input logic err, output word_t data);
		bus_transfer(1'b0, addr, 32'd0, err, data);
	endtask

	task automatic launch_job(input logic new_data, input logic err);
		if (new_data)
		begin
			apb_write(reg_data0, $random(seed), 1'b0);
			apb_write(reg_data1, $random(seed), 1'b0);
		end
		apb_write(reg_launch, {24'd0, next_tag}, err);
		next_tag = next_tag + 8'd1;
	endtask

	// Poll status until the queue holds at least n results
	task automatic wait_results(input int n);
		word_t status;
		do
			apb_read(reg_launch, 1'b0, status);
		while (int'(status[15:8]) < n);
	endtask

	task automatic drain(input int n);
		word_t data;
		for (int i = 0; i < n; i++)
		begin
			wait_results(1);
			apb_read(reg_result_lo, 1'b0, data);
			apb_read(reg_result_hi, 1'b0, data);
		end
	endtask

	initial
	begin
		word_t rd;
		int    filled;
		int    batch;
		apb = '0;
		expect_err = 1'b0;
		next_tag = 8'h01;
		reset = 1'b1;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Readback and status after reset
		apb_write(reg_data0, $random(seed), 1'b0);
		apb_write(reg_data1, $random(seed), 1'b0);
		apb_read(reg_data0, 1'b0, rd);
		apb_read(reg_data1, 1'b0, rd);
		apb_read(reg_launch, 1'b0, rd);

		// Empty queue reads
		apb_read(reg_result_hi, 1'b1, rd);
		apb_read(reg_result_lo, 1'b1, rd);
		apb_read(reg_launch, 1'b0, rd);

		launch_job(1'b1, 1'b0);
		drain(1);

		for (int i = 0; i < LANES; i++)
			launch_job(1'b1, 1'b0);
		wait_results(LANES);
		drain(LANES);

		// One launch more than there are lanes
		launch_job(1'b1, 1'b0);
		for (int i = 1; i < LANES; i++)
			launch_job(1'b0, 1'b0);
		launch_job(1'b0, 1'b1);
		wait_results(LANES);
		drain(LANES);

		//////////////////////////////////////////////////
		// Fill the queue, then stall every lane behind it
		filled = 0;
		while (filled < QUEUE_DEPTH)
		begin
			batch = (QUEUE_DEPTH - filled < LANES) ? QUEUE_DEPTH - filled : LANES;
			for (int i = 0; i < batch; i++)
				launch_job(1'b1, 1'b0);
			filled = filled + batch;
			wait_results(filled);
		end
		for (int i = 0; i < LANES; i++)
			launch_job(1'b1, 1'b0);
		apb_read(reg_launch, 1'b0, rd);
		launch_job(1'b0, 1'b1);
		drain(QUEUE_DEPTH + LANES);
		apb_read(reg_launch, 1'b0, rd);

		@(negedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0 && checks > 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: project.f
logic/tea_pkg.sv
logic/tea_result_queue.sv
logic/tea_lane.sv
logic/tea_apb_regs.sv
logic/tea_accel_top.sv
bench/tea_checker.sv
bench/tea_accel_tb.sv

// File: run.sh
#!/bin/sh
# Compile and run the TEA accelerator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module tea_accel_tb -o tea_accel_sim
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

out=$(./obj_dir/tea_accel_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "test passed"; then
	exit 0
fi
exit 1
